//--- include/length_table.svh
// length counter load values, indexed by the upper five bits of the 0x0B write
function automatic logic [7:0] length_lookup(input logic [4:0] idx);
	case (idx)
		5'd0:  length_lookup = 8'd10;
		5'd1:  length_lookup = 8'd254;
		5'd2:  length_lookup = 8'd20;
		5'd3:  length_lookup = 8'd2;
		5'd4:  length_lookup = 8'd40;
		5'd5:  length_lookup = 8'd4;
		5'd6:  length_lookup = 8'd80;
		5'd7:  length_lookup = 8'd6;
		5'd8:  length_lookup = 8'd160;
		5'd9:  length_lookup = 8'd8;
		5'd10: length_lookup = 8'd60;
		5'd11: length_lookup = 8'd10;
		5'd12: length_lookup = 8'd14;
		5'd13: length_lookup = 8'd12;
		5'd14: length_lookup = 8'd26;
		5'd15: length_lookup = 8'd14;
		5'd16: length_lookup = 8'd12;
		5'd17: length_lookup = 8'd16;
		5'd18: length_lookup = 8'd24;
		5'd19: length_lookup = 8'd18;
		5'd20: length_lookup = 8'd48;
		5'd21: length_lookup = 8'd20;
		5'd22: length_lookup = 8'd96;
		5'd23: length_lookup = 8'd22;
		5'd24: length_lookup = 8'd192;
		5'd25: length_lookup = 8'd24;
		5'd26: length_lookup = 8'd72;
		5'd27: length_lookup = 8'd26;
		5'd28: length_lookup = 8'd16;
		5'd29: length_lookup = 8'd28;
		5'd30: length_lookup = 8'd32;
		default: length_lookup = 8'd30;
	endcase
endfunction

//--- hdl/apu_reg_pkg.sv
package apu_reg_pkg;

	// register offsets within the audio block, low five address bits
	typedef logic [4:0] reg_addr_t;

	localparam reg_addr_t ADDR_LINEAR   = 5'h08;
	localparam reg_addr_t ADDR_TIMER_LO = 5'h0A;
	localparam reg_addr_t ADDR_TIMER_HI = 5'h0B;
	localparam reg_addr_t ADDR_STATUS   = 5'h15;
	localparam reg_addr_t ADDR_TEST     = 5'h1A;

	// triangle enable bit in the status write
	localparam int STATUS_TRI_BIT = 2;

	// 0x08 layout
	typedef struct packed {
		logic       ctrl;
		logic [6:0] reload;
	} lin_view_t;

	// 0x0B layout
	typedef struct packed {
		logic [4:0] len_idx;
		logic [2:0] timer_hi;
	} timer_hi_view_t;

	// one data byte, read through whichever view fits the address
	typedef union packed {
		lin_view_t      lin;
		timer_hi_view_t thi;
	} reg_wdata_u;

endpackage

//--- hdl/tri_wave_pkg.sv
package tri_wave_pkg;

	// period of the frequency timer
	localparam int TIMER_W = 11;

	// linear counter width, same as its reload field
	localparam int LIN_W = 7;

	// length counter width, matches the table entries
	localparam int LEN_W = 8;

	// index into the length table
	localparam int LEN_IDX_W = 5;

	// 32 steps per waveform period
	localparam int STEP_W = 5;

	typedef logic [STEP_W-1:0] step_t;

	// 4-bit output level
	typedef logic [3:0] sample_t;

endpackage

//--- hdl/tri_reg_decode.sv
module tri_reg_decode
	import apu_reg_pkg::*;
	import tri_wave_pkg::*;
(
	input  logic                 phi1,
	input  logic                 rst_n,
	input  logic                 wr,
	input  reg_addr_t            addr,
	input  reg_wdata_u           wdata,
	output logic                 ctrl,
	output logic [LIN_W-1:0]     lin_reload,
	output logic [TIMER_W-1:0]   period,
	output logic                 len_enable,
	output logic                 timer_hi_wr,
	output logic [LEN_IDX_W-1:0] len_index,
	output logic                 test_wr,
	output step_t                test_step
);

	// raw byte for the registers that have no field view
	logic [7:0] wbyte;

	assign wbyte = wdata;

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			ctrl        <= 1'b0;
			lin_reload  <= '0;
			period      <= '0;
			len_enable  <= 1'b0;
			timer_hi_wr <= 1'b0;
			len_index   <= '0;
			test_wr     <= 1'b0;
			test_step   <= '0;
		end else begin
			timer_hi_wr <= 1'b0;
			test_wr     <= 1'b0;
			if (wr) begin
				case (addr)
					ADDR_LINEAR: begin
						ctrl       <= wdata.lin.ctrl;
						lin_reload <= wdata.lin.reload;
					end
					ADDR_TIMER_LO: begin
						period[7:0] <= wbyte;
					end
					ADDR_TIMER_HI: begin
						period[TIMER_W-1:8] <= wdata.thi.timer_hi;
						len_index           <= wdata.thi.len_idx;
						timer_hi_wr         <= 1'b1;
					end
					ADDR_STATUS: begin
						len_enable <= wbyte[STATUS_TRI_BIT];
					end
					ADDR_TEST: begin
						// test register forces the step counter position
						test_step <= wbyte[STEP_W-1:0];
						test_wr   <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

//--- hdl/frame_seq.sv
module frame_seq #(
	parameter int QUARTER_TICKS = 3729
) (
	input  logic phi1,
	input  logic rst_n,
	output logic aclk_en,
	output logic quarter_pulse,
	output logic half_pulse
);

	localparam int CNT_W = (QUARTER_TICKS > 1) ? $clog2(QUARTER_TICKS) : 1;
	localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(QUARTER_TICKS - 1);

	logic [CNT_W-1:0] tick_cnt;
	logic             half_phase;
	logic             last_tick;

	assign last_tick = (tick_cnt == LAST_TICK);

	// pulses are one phi1 cycle wide and land on an aclk_en cycle
	assign quarter_pulse = aclk_en & last_tick;
	assign half_pulse    = quarter_pulse & half_phase;

	// half-rate audio clock enable
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			aclk_en <= 1'b0;
		end else begin
			aclk_en <= ~aclk_en;
		end
	end

	// count aclk ticks up to a quarter frame
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (aclk_en) begin
			if (last_tick) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// every second quarter frame is also a half frame
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			half_phase <= 1'b0;
		end else if (quarter_pulse) begin
			half_phase <= ~half_phase;
		end
	end

endmodule

//--- hdl/tri_linear_counter.sv
module tri_linear_counter
	import tri_wave_pkg::*;
(
	input  logic             phi1,
	input  logic             rst_n,
	input  logic             aclk_en,
	input  logic             quarter_pulse,
	input  logic             ctrl,
	input  logic [LIN_W-1:0] lin_reload,
	input  logic             timer_hi_wr,
	output logic             lin_nonzero
);

	logic [LIN_W-1:0] lin_cnt;
	logic             reload_flag;
	logic             qtick;

	// quarter frame only counts on an audio clock cycle
	assign qtick = quarter_pulse & aclk_en;

	assign lin_nonzero = (lin_cnt != '0);

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			lin_cnt <= '0;
		end else if (qtick) begin
			if (reload_flag) begin
				lin_cnt <= lin_reload;
			end else if (lin_nonzero) begin
				lin_cnt <= lin_cnt - 1'b1;
			end
		end
	end

	// set by a 0x0B write, and held while ctrl is set
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			reload_flag <= 1'b0;
		end else if (timer_hi_wr) begin
			reload_flag <= 1'b1;
		end else if (qtick && !ctrl) begin
			reload_flag <= 1'b0;
		end
	end

endmodule

//--- hdl/tri_length_counter.sv
module tri_length_counter
	import tri_wave_pkg::*;
(
	input  logic                 phi1,
	input  logic                 rst_n,
	input  logic                 half_pulse,
	input  logic                 ctrl,
	input  logic                 len_enable,
	input  logic                 timer_hi_wr,
	input  logic [LEN_IDX_W-1:0] len_index,
	output logic                 len_nonzero
);

	`include "length_table.svh"

	logic [LEN_W-1:0] len_cnt;
	logic             halt;

	// the control bit doubles as length halt
	assign halt = ctrl;

	assign len_nonzero = (len_cnt != '0);

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			len_cnt <= '0;
		end else if (!len_enable) begin
			len_cnt <= '0;
		end else if (timer_hi_wr) begin
			len_cnt <= length_lookup(len_index);
		end else if (half_pulse && !halt && len_nonzero) begin
			len_cnt <= len_cnt - 1'b1;
		end
	end

endmodule

//--- hdl/tri_freq_timer.sv
module tri_freq_timer
	import tri_wave_pkg::*;
(
	input  logic               phi1,
	input  logic               rst_n,
	input  logic [TIMER_W-1:0] period,
	output logic               fout
);

	logic [TIMER_W-1:0] timer_cnt;
	logic               at_zero;

	assign at_zero = (timer_cnt == '0);

	// reload at zero, so fout repeats every period+1 cycles
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			timer_cnt <= '0;
			fout      <= 1'b0;
		end else begin
			fout <= at_zero;
			if (at_zero) begin
				timer_cnt <= period;
			end else begin
				timer_cnt <= timer_cnt - 1'b1;
			end
		end
	end

endmodule

//--- hdl/tri_sequencer.sv
module tri_sequencer
	import tri_wave_pkg::*;
(
	input  logic    phi1,
	input  logic    rst_n,
	input  logic    fout,
	input  logic    lin_nonzero,
	input  logic    len_nonzero,
	input  logic    lock,
	input  logic    test_wr,
	input  step_t   test_step,
	output sample_t tri_out
);

	step_t step_q;
	step_t step_d;
	logic  step_en;

	// upper half ramps up, lower half is the inverted ramp down
	function automatic sample_t fold(input step_t s);
		return s[STEP_W-1] ? s[3:0] : ~s[3:0];
	endfunction

	assign step_en = fout & lin_nonzero & len_nonzero & ~lock;

	always_comb begin
		step_d = step_q;
		if (test_wr) begin
			step_d = test_step;
		end else if (step_en) begin
			step_d = step_q + 1'b1;
		end
	end

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			step_q  <= '0;
			// folded level of step 0
			tri_out <= 4'hF;
		end else begin
			step_q  <= step_d;
			tri_out <= fold(step_d);
		end
	end

endmodule

//--- hdl/tri_channel_top.sv
module tri_channel_top
	import apu_reg_pkg::*;
	import tri_wave_pkg::*;
#(
	parameter int QUARTER_TICKS = 3729
) (
	input  logic       phi1,
	input  logic       rst_n,
	input  logic       wr,
	input  reg_addr_t  addr,
	input  reg_wdata_u wdata,
	input  logic       lock,
	output sample_t    tri_out,
	output logic       len_active
);

	logic                 ctrl;
	logic [LIN_W-1:0]     lin_reload;
	logic [TIMER_W-1:0]   period;
	logic                 len_enable;
	logic                 timer_hi_wr;
	logic [LEN_IDX_W-1:0] len_index;
	logic                 test_wr;
	step_t                test_step;
	logic                 aclk_en;
	logic                 quarter_pulse;
	logic                 half_pulse;
	logic                 lin_nonzero;
	logic                 len_nonzero;
	logic                 fout;

	assign len_active = len_nonzero;

	tri_reg_decode u_decode (
		.phi1(phi1), .rst_n(rst_n), .wr(wr), .addr(addr), .wdata(wdata),
		.ctrl(ctrl), .lin_reload(lin_reload), .period(period), .len_enable(len_enable),
		.timer_hi_wr(timer_hi_wr), .len_index(len_index),
		.test_wr(test_wr), .test_step(test_step)
	);

	frame_seq #(.QUARTER_TICKS(QUARTER_TICKS)) u_frame (
		.phi1(phi1), .rst_n(rst_n), .aclk_en(aclk_en),
		.quarter_pulse(quarter_pulse), .half_pulse(half_pulse)
	);

	tri_linear_counter u_linear (
		.phi1(phi1), .rst_n(rst_n), .aclk_en(aclk_en), .quarter_pulse(quarter_pulse),
		.ctrl(ctrl), .lin_reload(lin_reload), .timer_hi_wr(timer_hi_wr),
		.lin_nonzero(lin_nonzero)
	);

	tri_length_counter u_length (
		.phi1(phi1), .rst_n(rst_n), .half_pulse(half_pulse), .ctrl(ctrl),
		.len_enable(len_enable), .timer_hi_wr(timer_hi_wr), .len_index(len_index),
		.len_nonzero(len_nonzero)
	);

	tri_freq_timer u_timer (.phi1(phi1), .rst_n(rst_n), .period(period), .fout(fout));

	tri_sequencer u_seq (
		.phi1(phi1), .rst_n(rst_n), .fout(fout), .lin_nonzero(lin_nonzero),
		.len_nonzero(len_nonzero), .lock(lock), .test_wr(test_wr),
		.test_step(test_step), .tri_out(tri_out)
	);

endmodule

//--- verification/tri_channel_tb.sv
module tri_channel_tb
	import apu_reg_pkg::*;
	import tri_wave_pkg::*;
();

	localparam int QTICKS = 8;

	`include "length_table.svh"

	logic       phi1;
	logic       rst_n;
	logic       wr;
	reg_addr_t  addr;
	reg_wdata_u wdata;
	logic       lock;
	sample_t    tri_out;
	logic       len_active;

	int         seed;
	int         tone_period;

	tri_channel_top #(.QUARTER_TICKS(QTICKS)) DUT (
		.phi1(phi1), .rst_n(rst_n), .wr(wr), .addr(addr), .wdata(wdata),
		.lock(lock), .tri_out(tri_out), .len_active(len_active)
	);

	always #10 phi1 = ~phi1;

	task automatic stop_on_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic expect_value(input string name, input int exp, input int act);
		assert (act == exp) else begin
			$display("Error at time %0t: %s expected %0d actual %0d", $time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		stop_on_failure();
	endtask

	// while reset is held, the next edge must see the idle output
	reset_state: assert property (@(posedge phi1) !rst_n |=> (tri_out == 4'hF && !len_active))
		else begin
			$display("Error at time %0t: tri_out expected 15 actual %0d, len_active expected 0 actual %0d",
				$time, tri_out, len_active);
			stop_on_failure();
		end

	// steps 16..31 ramp up, steps 0..15 ramp down
	function automatic sample_t folded_level(input step_t s);
		if (s[4]) begin
			return s[3:0];
		end else begin
			return 4'd15 - s[3:0];
		end
	endfunction

	function automatic reg_wdata_u linear_byte(input logic c, input logic [6:0] r);
		reg_wdata_u b;
		b.lin.ctrl   = c;
		b.lin.reload = r;
		return b;
	endfunction

	function automatic reg_wdata_u timer_hi_byte(input logic [4:0] idx, input logic [2:0] hi);
		reg_wdata_u b;
		b.thi.len_idx  = idx;
		b.thi.timer_hi = hi;
		return b;
	endfunction

	task automatic write_reg(input reg_addr_t a, input reg_wdata_u d);
		@(posedge phi1);
		#2;
		wr    = 1'b1;
		addr  = a;
		wdata = d;
		@(posedge phi1);
		#2;
		wr = 1'b0;
	endtask

	task automatic next_sample();
		@(posedge phi1);
		#1;
	endtask

	task automatic wait_level_change(input sample_t from, input int limit, input string what);
		int n;
		n = 0;
		while (tri_out == from && n < limit) begin
			next_sample();
			n++;
		end
		if (tri_out == from) begin
			report_timeout(what);
		end
	endtask

	// returns once tri_out has not moved for quiet cycles
	task automatic wait_until_steady(input int quiet, input int limit, input string what);
		sample_t last;
		int      n;
		int      still;
		last  = tri_out;
		n     = 0;
		still = 0;
		while (still < quiet && n < limit) begin
			next_sample();
			n++;
			if (tri_out == last) begin
				still++;
			end else begin
				last  = tri_out;
				still = 0;
			end
		end
		if (still < quiet) begin
			report_timeout(what);
		end
	endtask

	task automatic expect_hold(input int cycles);
		sample_t held;
		held = tri_out;
		repeat (cycles) begin
			next_sample();
			expect_value("tri_out", int'(held), int'(tri_out));
		end
	endtask

	initial begin
		step_t step;
		step_t t_step;
		int    n;
		int    limit;
		phi1  = 1'b0;
		rst_n = 1'b0;
		wr    = 1'b0;
		addr  = '0;
		wdata = '0;
		lock  = 1'b0;
		seed  = 53;
		repeat (4) @(posedge phi1);
		#2;
		rst_n = 1'b1;
		next_sample();
		expect_value("tri_out", 15, int'(tri_out));
		expect_value("len_active", 0, int'(len_active));

		// period alone, no length loaded
		tone_period = 3 + ($unsigned($random(seed)) % 18);
		write_reg(ADDR_TIMER_LO, tone_period[7:0]);
		write_reg(ADDR_TIMER_HI, timer_hi_byte(5'd0, 3'd0));
		repeat (200) begin
			next_sample();
			expect_value("tri_out", 15, int'(tri_out));
			expect_value("len_active", 0, int'(len_active));
		end

		// running waveform, every step checked against the fold rule
		tone_period = 3 + ($unsigned($random(seed)) % 18);
		write_reg(ADDR_STATUS, 8'h04);
		write_reg(ADDR_LINEAR, linear_byte(1'b1, 7'd20));
		write_reg(ADDR_TIMER_LO, tone_period[7:0]);
		write_reg(ADDR_TIMER_HI, timer_hi_byte(5'd1, 3'd0));
		wait_level_change(4'd15, 100, "the first waveform step");
		step = 5'd1;
		expect_value("tri_out", int'(folded_level(step)), int'(tri_out));
		repeat (40) begin
			repeat (tone_period) begin
				next_sample();
				expect_value("tri_out", int'(folded_level(step)), int'(tri_out));
			end
			next_sample();
			step = step + 1'b1;
			expect_value("tri_out", int'(folded_level(step)), int'(tri_out));
		end

		repeat (4) begin
			t_step = step_t'($unsigned($random(seed)));
			write_reg(ADDR_TEST, {3'b000, t_step});
			next_sample();
			expect_value("tri_out", int'(folded_level(t_step)), int'(tri_out));
			repeat (3) next_sample();
		end

		// length of 2 half frames with halt clear
		write_reg(ADDR_LINEAR, linear_byte(1'b0, 7'd100));
		write_reg(ADDR_TIMER_HI, timer_hi_byte(5'd3, 3'd0));
		expect_value("len_active", 1, int'(len_active));
		limit = (int'(length_lookup(5'd3)) + 1) * 4 * QTICKS + 16;
		n = 0;
		while (len_active && n < limit) begin
			next_sample();
			n++;
		end
		if (len_active) begin
			report_timeout("len_active to fall after the length count ran out");
		end
		expect_hold(3 * (tone_period + 1));

		// linear count of 1 runs out long before the length does
		write_reg(ADDR_LINEAR, linear_byte(1'b0, 7'd1));
		write_reg(ADDR_TIMER_HI, timer_hi_byte(5'd1, 3'd0));
		wait_until_steady(3 * (tone_period + 1), 600,
			"tri_out to stop after the linear count ran out");
		expect_value("len_active", 1, int'(len_active));
		expect_hold(3 * (tone_period + 1));
		expect_value("len_active", 1, int'(len_active));

		write_reg(ADDR_LINEAR, linear_byte(1'b1, 7'd20));
		write_reg(ADDR_TIMER_HI, timer_hi_byte(5'd1, 3'd0));
		wait_level_change(tri_out, 4 * (tone_period + 1) + 32, "stepping to restart");
		@(posedge phi1);
		#2;
		lock = 1'b1;
		next_sample();
		expect_hold(3 * (tone_period + 1));
		#1;
		lock = 1'b0;
		wait_level_change(tri_out, 2 * (tone_period + 1) + 4,
			"stepping to resume after lock was released");

		// clearing the enable bit empties the length counter one cycle later
		write_reg(ADDR_STATUS, 8'h00);
		expect_value("len_active", 1, int'(len_active));
		next_sample();
		expect_value("len_active", 0, int'(len_active));

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
hdl/apu_reg_pkg.sv
hdl/tri_wave_pkg.sv
hdl/tri_reg_decode.sv
hdl/frame_seq.sv
hdl/tri_linear_counter.sv
hdl/tri_length_counter.sv
hdl/tri_freq_timer.sv
hdl/tri_sequencer.sv
hdl/tri_channel_top.sv
verification/tri_channel_tb.sv
